//--- hdl/rv32i_pkg.sv
// rv32i pipeline package
// shared widths, opcode and ALU encodings, control word and the
// reset and bubble constants of the five-stage pipeline
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] word_t;    // data, address or instruction
    typedef logic [4:0] reg_idx_t;  // register number

    // only the supported opcodes, op_nop marks a bubble
    typedef enum logic [6:0] {
        op_nop   = 7'b0000000,
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111,
        op_br    = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_none,
        fwd_exmem,
        fwd_memwb
    } fwd_sel_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_imm,
        wb_load
    } wb_sel_t;

    typedef struct packed {
        opcode_t opcode;
        alu_op_t alu_op;
        logic imm_op;        // operand b from immediate
        logic br_ne;         // bne, else beq
        logic data_read;
        logic data_write;
        logic load_regfile;
        wb_sel_t wb_sel;
    } ctrl_word_t;

    localparam word_t reset_pc = 32'h0000_0000;
    localparam word_t nop_instr = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

//--- hdl/pipeline_status_if.sv
// pipeline status interface
// carries the global stall enable, the branch flush, the register
// numbers of EX, MEM and WB and the operand forwarding selects
`default_nettype none

interface pipeline_status_if;

    logic pipeline_en;                  // all stage buffers load
    logic flush;                        // taken branch in execute
    rv32i_pkg::reg_idx_t rs1_ex;
    rv32i_pkg::reg_idx_t rs2_ex;
    rv32i_pkg::reg_idx_t rd_mem;
    logic wr_mem;                       // MEM writes rd_mem
    logic mem_access;                   // MEM holds a load or store
    rv32i_pkg::reg_idx_t rd_wb;
    logic wr_wb;
    rv32i_pkg::fwd_sel_t fwd_a;
    rv32i_pkg::fwd_sel_t fwd_b;

    modport ctrl (output pipeline_en, flush, fwd_a, fwd_b,
                  input rs1_ex, rs2_ex, rd_mem, wr_mem, mem_access, rd_wb, wr_wb);
    modport fetch (input pipeline_en, flush);
    modport decode (input pipeline_en, flush, output rs1_ex, rs2_ex);
    modport execute (input pipeline_en, fwd_a, fwd_b, output rd_mem, wr_mem, mem_access);
    modport memwb (input pipeline_en, output rd_wb, wr_wb);

endinterface

`default_nettype wire

//--- hdl/fetch_stage.sv
// fetch stage
// program counter with the next-PC choice and the IF/ID buffer
`default_nettype none

module fetch_stage (
    input  logic clk,
    input  logic reset,
    input  logic inst_resp,
    input  rv32i_pkg::word_t inst_rdata,
    input  logic take_branch,
    input  rv32i_pkg::word_t branch_target,
    output logic inst_read,
    output rv32i_pkg::word_t inst_addr,
    output rv32i_pkg::word_t instr_id,
    output rv32i_pkg::word_t pc_id,
    pipeline_status_if.fetch st
);

    assign inst_read = !reset;  // fetch continuously out of reset

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            inst_addr <= rv32i_pkg::reset_pc;
            instr_id <= rv32i_pkg::nop_instr;
            pc_id <= rv32i_pkg::reset_pc;
        end
        else if (st.pipeline_en && inst_resp)
        begin
            inst_addr <= take_branch ? branch_target : inst_addr + 32'd4;
            instr_id <= st.flush ? rv32i_pkg::nop_instr : inst_rdata;
            pc_id <= inst_addr;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
// decode stage
// decodes the instruction into a control word and immediate, reads the
// register file with write-through from writeback, loads ID/EX
`default_nettype none

module decode_stage (
    input  logic clk,
    input  logic reset,
    input  rv32i_pkg::word_t instr_id,
    input  rv32i_pkg::word_t pc_id,
    input  logic wb_we,
    input  rv32i_pkg::reg_idx_t wb_rd,
    input  rv32i_pkg::word_t wb_data,
    output rv32i_pkg::ctrl_word_t ctrl_ex,
    output rv32i_pkg::word_t rs1_val_ex,
    output rv32i_pkg::word_t rs2_val_ex,
    output rv32i_pkg::word_t imm_ex,
    output rv32i_pkg::word_t pc_ex,
    output rv32i_pkg::reg_idx_t rd_ex,
    pipeline_status_if.decode st
);

    rv32i_pkg::word_t regs [32];
    rv32i_pkg::ctrl_word_t ctrl;
    rv32i_pkg::word_t imm, rs1_val, rs2_val;
    rv32i_pkg::reg_idx_t rs1, rs2, rd;
    logic [2:0] funct3;

    assign rs1 = instr_id[19:15];
    assign rs2 = instr_id[24:20];
    assign rd = instr_id[11:7];
    assign funct3 = instr_id[14:12];

    always_comb
    begin
        ctrl = '0;  // bubble unless decoded
        ctrl.opcode = rv32i_pkg::op_nop;
        case (funct3)
            3'b100: ctrl.alu_op = rv32i_pkg::alu_xor;
            3'b110: ctrl.alu_op = rv32i_pkg::alu_or;
            3'b111: ctrl.alu_op = rv32i_pkg::alu_and;
            default: ctrl.alu_op = rv32i_pkg::alu_add;
        endcase
        case (instr_id[6:0])
            rv32i_pkg::op_reg:
            begin
                ctrl.opcode = rv32i_pkg::op_reg;
                ctrl.load_regfile = 1'b1;
                if (funct3 == 3'b000 && instr_id[30])
                    ctrl.alu_op = rv32i_pkg::alu_sub;
            end
            rv32i_pkg::op_imm:
            begin
                ctrl.opcode = rv32i_pkg::op_imm;
                ctrl.imm_op = 1'b1;
                ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_lui:
            begin
                ctrl.opcode = rv32i_pkg::op_lui;
                ctrl.load_regfile = 1'b1;
                ctrl.wb_sel = rv32i_pkg::wb_imm;
            end
            rv32i_pkg::op_load:
            begin
                ctrl.opcode = rv32i_pkg::op_load;
                ctrl.alu_op = rv32i_pkg::alu_add;  // base plus offset
                ctrl.imm_op = 1'b1;
                ctrl.data_read = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.wb_sel = rv32i_pkg::wb_load;
            end
            rv32i_pkg::op_store:
            begin
                ctrl.opcode = rv32i_pkg::op_store;
                ctrl.alu_op = rv32i_pkg::alu_add;
                ctrl.imm_op = 1'b1;
                ctrl.data_write = 1'b1;
            end
            rv32i_pkg::op_br:
            begin
                ctrl.opcode = rv32i_pkg::op_br;
                ctrl.br_ne = funct3[0];
            end
            default: ;  // unsupported, leave as bubble
        endcase
    end

    // immediate formats
    always_comb
    begin
        case (instr_id[6:0])
            rv32i_pkg::op_store:
                imm = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
            rv32i_pkg::op_br:
                imm = {{19{instr_id[31]}}, instr_id[31], instr_id[7],
                       instr_id[30:25], instr_id[11:8], 1'b0};
            rv32i_pkg::op_lui:
                imm = {instr_id[31:12], 12'h000};
            default:
                imm = {{20{instr_id[31]}}, instr_id[31:20]};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (wb_we && wb_rd != 5'd0)
            regs[wb_rd] <= wb_data;
    end

    // write-through so decode sees this cycle's writeback
    assign rs1_val = (rs1 == 5'd0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

    always_ff @(posedge clk)
    begin
        if (reset || (st.pipeline_en && st.flush))
        begin
            ctrl_ex <= '0;
            rd_ex <= '0;
            st.rs1_ex <= '0;
            st.rs2_ex <= '0;
        end
        else if (st.pipeline_en)
        begin
            ctrl_ex <= ctrl;
            rd_ex <= rd;
            st.rs1_ex <= rs1;
            st.rs2_ex <= rs2;
        end
    end

    always_ff @(posedge clk)
    begin
        if (st.pipeline_en)
        begin
            rs1_val_ex <= rs1_val;
            rs2_val_ex <= rs2_val;
            imm_ex <= imm;
            pc_ex <= pc_id;
        end
    end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
// execute stage
// forwarding muxes, ALU, beq/bne compare with target, and EX/MEM buffer
`default_nettype none

module execute_stage (
    input  logic clk,
    input  logic reset,
    input  rv32i_pkg::ctrl_word_t ctrl_ex,
    input  rv32i_pkg::word_t rs1_val_ex,
    input  rv32i_pkg::word_t rs2_val_ex,
    input  rv32i_pkg::word_t imm_ex,
    input  rv32i_pkg::word_t pc_ex,
    input  rv32i_pkg::reg_idx_t rd_ex,
    input  rv32i_pkg::reg_idx_t rs2_ex,
    input  rv32i_pkg::word_t exmem_fwd,
    input  rv32i_pkg::word_t memwb_fwd,
    output logic is_branch,
    output logic branch_cond,
    output rv32i_pkg::word_t branch_target,
    output rv32i_pkg::ctrl_word_t ctrl_mem,
    output rv32i_pkg::word_t alu_mem,
    output rv32i_pkg::word_t store_mem,
    output rv32i_pkg::reg_idx_t rd_mem_out,
    output rv32i_pkg::reg_idx_t rs2_mem_out,
    pipeline_status_if.execute st
);

    rv32i_pkg::word_t op_a, rs2_fwd, op_b, alu_out, result;

    function automatic rv32i_pkg::word_t pick(rv32i_pkg::fwd_sel_t sel,
                                              rv32i_pkg::word_t reg_val,
                                              rv32i_pkg::word_t from_mem,
                                              rv32i_pkg::word_t from_wb);
        case (sel)
            rv32i_pkg::fwd_exmem: return from_mem;
            rv32i_pkg::fwd_memwb: return from_wb;
            default: return reg_val;
        endcase
    endfunction

    assign op_a = pick(st.fwd_a, rs1_val_ex, exmem_fwd, memwb_fwd);
    assign rs2_fwd = pick(st.fwd_b, rs2_val_ex, exmem_fwd, memwb_fwd);
    assign op_b = ctrl_ex.imm_op ? imm_ex : rs2_fwd;

    always_comb
    begin
        case (ctrl_ex.alu_op)
            rv32i_pkg::alu_sub: alu_out = op_a - op_b;
            rv32i_pkg::alu_and: alu_out = op_a & op_b;
            rv32i_pkg::alu_or:  alu_out = op_a | op_b;
            rv32i_pkg::alu_xor: alu_out = op_a ^ op_b;
            default:            alu_out = op_a + op_b;
        endcase
    end

    // lui carries its immediate as the result
    assign result = (ctrl_ex.wb_sel == rv32i_pkg::wb_imm) ? imm_ex : alu_out;

    assign is_branch = (ctrl_ex.opcode == rv32i_pkg::op_br);
    assign branch_cond = ctrl_ex.br_ne ? (op_a != rs2_fwd) : (op_a == rs2_fwd);
    assign branch_target = pc_ex + imm_ex;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl_mem <= '0;
            rd_mem_out <= '0;
        end
        else if (st.pipeline_en)
        begin
            ctrl_mem <= ctrl_ex;
            rd_mem_out <= rd_ex;
        end
    end

    always_ff @(posedge clk)
    begin
        if (st.pipeline_en)
        begin
            alu_mem <= result;
            store_mem <= rs2_fwd;  // already forwarded
            rs2_mem_out <= rs2_ex;
        end
    end

    assign st.rd_mem = rd_mem_out;
    assign st.wr_mem = ctrl_mem.load_regfile;
    assign st.mem_access = ctrl_mem.data_read | ctrl_mem.data_write;

endmodule

`default_nettype wire

//--- hdl/memory_writeback.sv
// memory and writeback stages
// drives the data port, forwards store data from writeback, holds the
// MEM/WB buffer and picks the register file write value
`default_nettype none

module memory_writeback (
    input  logic clk,
    input  logic reset,
    input  rv32i_pkg::ctrl_word_t ctrl_mem,
    input  rv32i_pkg::word_t alu_mem,
    input  rv32i_pkg::word_t store_mem,
    input  rv32i_pkg::reg_idx_t rd_mem,
    input  rv32i_pkg::reg_idx_t rs2_mem,
    input  logic data_resp,
    input  rv32i_pkg::word_t data_rdata,
    output logic data_read,
    output logic data_write,
    output rv32i_pkg::word_t data_addr,
    output rv32i_pkg::word_t data_wdata,
    output rv32i_pkg::word_t exmem_fwd,
    output rv32i_pkg::word_t memwb_fwd,
    output logic wb_we,
    output rv32i_pkg::reg_idx_t wb_rd,
    output rv32i_pkg::word_t wb_data,
    pipeline_status_if.memwb st
);

    rv32i_pkg::wb_sel_t wb_sel;
    rv32i_pkg::word_t alu_wb, load_wb;
    logic store_fwd;

    assign data_read = ctrl_mem.data_read;
    assign data_write = ctrl_mem.data_write;
    assign data_addr = alu_mem;

    // older write to the store's data register now in writeback
    assign store_fwd = ctrl_mem.data_write && wb_we && wb_rd != 5'd0 && wb_rd == rs2_mem;
    assign data_wdata = store_fwd ? memwb_fwd : store_mem;

    // load data comes straight off the read port
    assign exmem_fwd = (ctrl_mem.wb_sel == rv32i_pkg::wb_load) ? data_rdata : alu_mem;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_we <= 1'b0;
            wb_rd <= '0;
            wb_sel <= rv32i_pkg::wb_alu;
        end
        else if (st.pipeline_en)
        begin
            wb_we <= ctrl_mem.load_regfile;
            wb_rd <= rd_mem;
            wb_sel <= ctrl_mem.wb_sel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (st.pipeline_en)
            alu_wb <= alu_mem;
        if (st.pipeline_en && ctrl_mem.data_read && data_resp)
            load_wb <= data_rdata;
    end

    always_comb
    begin
        case (wb_sel)
            rv32i_pkg::wb_load: wb_data = load_wb;
            default:            wb_data = alu_wb;  // alu or lui immediate
        endcase
    end

    assign memwb_fwd = wb_data;
    assign st.rd_wb = wb_rd;
    assign st.wr_wb = wb_we;

endmodule

`default_nettype wire

//--- hdl/pipeline_control.sv
// pipeline control
// global stall enable, branch decision with flush, and the forwarding
// selects for both ALU operands
`default_nettype none

module pipeline_control (
    input  logic inst_resp,
    input  logic data_resp,
    input  logic branch_cond,
    input  logic is_branch,
    output logic take_branch,
    pipeline_status_if.ctrl st
);

    logic a_mem, a_wb, b_mem, b_wb;

    // true when a writing stage targets rs, never for x0
    function automatic logic hit(rv32i_pkg::reg_idx_t rs,
                                 rv32i_pkg::reg_idx_t rd,
                                 logic wr);
        return wr && rd != 5'd0 && rd == rs;
    endfunction

    // stall on a missing instruction or a pending data response
    assign st.pipeline_en = inst_resp && (data_resp || !st.mem_access);

    assign take_branch = is_branch && branch_cond;
    assign st.flush = take_branch;

    assign a_mem = hit(st.rs1_ex, st.rd_mem, st.wr_mem);
    assign a_wb = hit(st.rs1_ex, st.rd_wb, st.wr_wb);
    assign b_mem = hit(st.rs2_ex, st.rd_mem, st.wr_mem);
    assign b_wb = hit(st.rs2_ex, st.rd_wb, st.wr_wb);

    // EX/MEM is younger so it wins
    always_comb
    begin
        if (a_mem)
            st.fwd_a = rv32i_pkg::fwd_exmem;
        else if (a_wb)
            st.fwd_a = rv32i_pkg::fwd_memwb;
        else
            st.fwd_a = rv32i_pkg::fwd_none;

        if (b_mem)
            st.fwd_b = rv32i_pkg::fwd_exmem;
        else if (b_wb)
            st.fwd_b = rv32i_pkg::fwd_memwb;
        else
            st.fwd_b = rv32i_pkg::fwd_none;
    end

endmodule

`default_nettype wire

//--- hdl/rv32i_pipeline.sv
// rv32i pipeline top level
// five-stage integer pipeline with separate instruction and data ports
`default_nettype none

module rv32i_pipeline (
    input  logic clk,
    input  logic reset,
    input  logic inst_resp,
    input  rv32i_pkg::word_t inst_rdata,
    input  logic data_resp,
    input  rv32i_pkg::word_t data_rdata,
    output logic inst_read,
    output rv32i_pkg::word_t inst_addr,
    output logic data_read,
    output logic data_write,
    output rv32i_pkg::word_t data_addr,
    output rv32i_pkg::word_t data_wdata
);

    pipeline_status_if st ();

    logic take_branch, is_branch, branch_cond, wb_we;
    rv32i_pkg::word_t branch_target, instr_id, pc_id;
    rv32i_pkg::ctrl_word_t ctrl_ex, ctrl_mem;
    rv32i_pkg::word_t rs1_val_ex, rs2_val_ex, imm_ex, pc_ex;
    rv32i_pkg::word_t alu_mem, store_mem, exmem_fwd, memwb_fwd, wb_data;
    rv32i_pkg::reg_idx_t rd_ex, rd_mem, rs2_mem, wb_rd;

    pipeline_control i_control (
        .inst_resp(inst_resp), .data_resp(data_resp),
        .branch_cond(branch_cond), .is_branch(is_branch),
        .take_branch(take_branch), .st(st.ctrl)
    );

    fetch_stage i_fetch (
        .clk(clk), .reset(reset),
        .inst_resp(inst_resp), .inst_rdata(inst_rdata),
        .take_branch(take_branch), .branch_target(branch_target),
        .inst_read(inst_read), .inst_addr(inst_addr),
        .instr_id(instr_id), .pc_id(pc_id), .st(st.fetch)
    );

    decode_stage i_decode (
        .clk(clk), .reset(reset), .instr_id(instr_id), .pc_id(pc_id),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data),
        .ctrl_ex(ctrl_ex), .rs1_val_ex(rs1_val_ex), .rs2_val_ex(rs2_val_ex),
        .imm_ex(imm_ex), .pc_ex(pc_ex), .rd_ex(rd_ex), .st(st.decode)
    );

    execute_stage i_execute (
        .clk(clk), .reset(reset), .ctrl_ex(ctrl_ex),
        .rs1_val_ex(rs1_val_ex), .rs2_val_ex(rs2_val_ex), .imm_ex(imm_ex),
        .pc_ex(pc_ex), .rd_ex(rd_ex), .rs2_ex(st.rs2_ex),
        .exmem_fwd(exmem_fwd), .memwb_fwd(memwb_fwd),
        .is_branch(is_branch), .branch_cond(branch_cond),
        .branch_target(branch_target), .ctrl_mem(ctrl_mem), .alu_mem(alu_mem),
        .store_mem(store_mem), .rd_mem_out(rd_mem), .rs2_mem_out(rs2_mem),
        .st(st.execute)
    );

    memory_writeback i_memwb (
        .clk(clk), .reset(reset), .ctrl_mem(ctrl_mem), .alu_mem(alu_mem),
        .store_mem(store_mem), .rd_mem(rd_mem), .rs2_mem(rs2_mem),
        .data_resp(data_resp), .data_rdata(data_rdata),
        .data_read(data_read), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .exmem_fwd(exmem_fwd), .memwb_fwd(memwb_fwd),
        .wb_we(wb_we), .wb_rd(wb_rd), .wb_data(wb_data), .st(st.memwb)
    );

endmodule

`default_nettype wire

//--- sim/rv32i_pipeline_checker.sv
// rv32i pipeline checker
// concurrent assertions on the instruction and data ports, bound to the top level
`default_nettype none

module rv32i_pipeline_checker (
    input  logic clk,
    input  logic reset,
    input  logic inst_resp,
    input  logic data_resp,
    input  logic data_read,
    input  logic data_write,
    input  rv32i_pkg::word_t inst_addr,
    input  rv32i_pkg::word_t data_addr
);

    // a word access is either a load or a store
    read_write_exclusive: assert property (@(posedge clk) !(data_read && data_write))
        else $error("data_read and data_write both high");

    // MEM holds a bubble once reset has been seen
    idle_in_reset: assert property (@(posedge clk) reset |=> !data_read && !data_write)
        else $error("data port active during reset");

    fetch_addr_held: assert property (@(posedge clk) disable iff (reset)
        !inst_resp |=> $stable(inst_addr))
        else $error("inst_addr moved without inst_resp");

    data_addr_held: assert property (@(posedge clk) disable iff (reset)
        (data_read || data_write) && !data_resp |=> $stable(data_addr))
        else $error("data_addr moved during a pending access");

endmodule

bind rv32i_pipeline rv32i_pipeline_checker i_checker (.*);

`default_nettype wire

//--- sim/rv32i_pipeline_tb.sv
// rv32i pipeline testbench
// instruction and data memory models with random response delays,
// a program table with expected stores, and in-order store checks
`default_nettype none

module rv32i_pipeline_tb;

    localparam int table_size = 30;
    localparam int timeout_cycles = 400;  // per expected store

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic inst_resp = 1'b0;
    logic data_resp = 1'b0;
    logic [31:0] inst_rdata;
    logic [31:0] data_rdata;
    logic inst_read, data_read, data_write;
    logic [31:0] inst_addr, data_addr, data_wdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] row_instr [table_size];
    logic row_store [table_size];
    logic [31:0] row_addr [table_size];
    logic [31:0] row_data [table_size];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    int n_rows = 0;
    int store_idx = 0;
    integer seed = 32'h41cd;
    integer rnd;
    logic [1:0] inst_cnt = 2'd0;
    logic [1:0] data_cnt = 2'd0;

    rv32i_pipeline i_rv32i_pipeline (
        .clk(clk), .reset(reset),
        .inst_resp(inst_resp), .inst_rdata(inst_rdata),
        .data_resp(data_resp), .data_rdata(data_rdata),
        .inst_read(inst_read), .inst_addr(inst_addr),
        .data_read(data_read), .data_write(data_write),
        .data_addr(data_addr), .data_wdata(data_wdata)
    );

    always #50 clk = ~clk;

    assign inst_rdata = imem[inst_addr[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic add_row(logic [31:0] instr, logic st, logic [31:0] addr, logic [31:0] data);
        row_instr[n_rows] = instr;
        row_store[n_rows] = st;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        n_rows++;
    endtask

    task automatic fill_table;
        add_row(i_type(12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011), 1'b0, '0, '0);  // x1 = 5
        add_row(i_type(12'd7, 5'd1, 3'b000, 5'd2, 7'b0010011), 1'b0, '0, '0);  // x2 = 12
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1'b0, '0, '0);        // x3 = 17
        add_row(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4), 1'b0, '0, '0);        // x4 = 12
        add_row(r_type(7'h00, 5'd3, 5'd4, 3'b100, 5'd5), 1'b0, '0, '0);        // x5 = 12 ^ 17
        add_row(s_type(12'h040, 5'd5, 5'd0), 1'b1, 32'h40, 32'h1d);
        add_row(s_type(12'h044, 5'd3, 5'd0), 1'b1, 32'h44, 32'h11);
        add_row({20'h12345, 5'd6, 7'b0110111}, 1'b0, '0, '0);                   // lui x6
        add_row(i_type(12'h678, 5'd6, 3'b110, 5'd6, 7'b0010011), 1'b0, '0, '0);
        add_row(s_type(12'h048, 5'd6, 5'd0), 1'b1, 32'h48, 32'h1234_5678);
        add_row(i_type(12'h048, 5'd0, 3'b010, 5'd7, 7'b0000011), 1'b0, '0, '0); // lw x7
        add_row(r_type(7'h00, 5'd1, 5'd7, 3'b000, 5'd8), 1'b0, '0, '0);        // load use
        add_row(s_type(12'h04c, 5'd8, 5'd0), 1'b1, 32'h4c, 32'h1234_567d);
        add_row(i_type(12'h040, 5'd0, 3'b010, 5'd9, 7'b0000011), 1'b0, '0, '0); // lw x9
        add_row(s_type(12'h050, 5'd9, 5'd0), 1'b1, 32'h50, 32'h1d);            // store of loaded reg
        add_row(i_type(12'h0ff, 5'd6, 3'b111, 5'd10, 7'b0010011), 1'b0, '0, '0);
        add_row(s_type(12'h054, 5'd10, 5'd0), 1'b1, 32'h54, 32'h78);
        add_row(b_type(13'd12, 5'd1, 5'd1, 3'b000), 1'b0, '0, '0);             // beq taken
        add_row(s_type(12'h058, 5'd1, 5'd0), 1'b0, '0, '0);                    // skipped
        add_row(s_type(12'h05c, 5'd2, 5'd0), 1'b0, '0, '0);                    // skipped
        add_row(b_type(13'd12, 5'd2, 5'd1, 3'b001), 1'b0, '0, '0);             // bne taken
        add_row(s_type(12'h058, 5'd1, 5'd0), 1'b0, '0, '0);
        add_row(s_type(12'h05c, 5'd2, 5'd0), 1'b0, '0, '0);
        add_row(b_type(13'd8, 5'd2, 5'd1, 3'b000), 1'b0, '0, '0);              // beq not taken
        add_row(s_type(12'h060, 5'd2, 5'd0), 1'b1, 32'h60, 32'h0c);
        add_row(i_type(12'd99, 5'd0, 3'b000, 5'd0, 7'b0010011), 1'b0, '0, '0); // writes x0
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 1'b0, '0, '0);
        add_row(s_type(12'h064, 5'd0, 5'd0), 1'b1, 32'h64, 32'h0);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd11), 1'b0, '0, '0);       // x11 = 13
        add_row(s_type(12'h068, 5'd11, 5'd0), 1'b1, 32'h68, 32'h0d);
    endtask

    task automatic wait_for_store(int idx);
        int cycles;
        cycles = 0;
        while (store_idx <= idx)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles)
            begin
                $display("timeout while waiting for store number %0d", idx);
                $display("sim failed");
                $fatal(1);
            end
        end
    endtask

    // instruction and data memory models
    always @(posedge clk)
    begin
        // instruction port, resp comes back after a random gap
        if (reset)
        begin
            inst_resp <= 1'b0;
            inst_cnt <= 2'd0;
        end
        else
        begin
            assert (inst_read)
            else
            begin
                $display("error: inst_read 0x%0h, expected 0x1", inst_read);
                $display("sim failed");
                $fatal(1);
            end
            if (inst_resp)
            begin
                rnd = $random(seed);
                inst_resp <= 1'b0;
                inst_cnt <= rnd[1:0];
            end
            else if (inst_cnt == 2'd0)
                inst_resp <= 1'b1;
            else
                inst_cnt <= inst_cnt - 2'd1;
        end

        // data port, resp held until the pipeline moves on
        if (reset)
        begin
            data_resp <= 1'b0;
            data_cnt <= 2'd0;
        end
        else if (!(data_read || data_write))
            data_resp <= 1'b0;  // gap drawn at the last access carries over
        else if (data_resp)
        begin
            if (data_write)
                dmem[data_addr[7:2]] <= data_wdata;
            if (inst_resp)
            begin
                rnd = $random(seed);
                data_resp <= 1'b0;
                data_cnt <= rnd[1:0];
            end
        end
        else if (data_cnt == 2'd0)
            data_resp <= 1'b1;
        else
            data_cnt <= data_cnt - 2'd1;
    end

    // a store completes on an edge where the pipeline is enabled
    always @(posedge clk)
    begin
        if (!reset && data_write && data_resp && inst_resp)
        begin
            assert (store_idx < exp_addr_q.size())
            else
            begin
                $display("an extra store appeared after the last expected one");
                $display("sim failed");
                $fatal(1);
            end
            assert (data_addr == exp_addr_q[store_idx])
            else
            begin
                $display("error: data_addr 0x%08h, expected 0x%08h",
                         data_addr, exp_addr_q[store_idx]);
                $display("sim failed");
                $fatal(1);
            end
            assert (data_wdata == exp_data_q[store_idx])
            else
            begin
                $display("error: data_wdata 0x%08h, expected 0x%08h",
                         data_wdata, exp_data_q[store_idx]);
                $display("sim failed");
                $fatal(1);
            end
            store_idx <= store_idx + 1;
        end
    end

    initial
    begin
        fill_table();
        for (int i = 0; i < 64; i++)
        begin
            imem[i] = 32'h0000_0013;  // nop past the program
            dmem[i] = 32'hdead_0000 ^ (i << 2);
        end
        for (int i = 0; i < n_rows; i++)
            imem[i] = row_instr[i];
        for (int i = 0; i < n_rows; i++)
        begin
            if (row_store[i])
            begin
                exp_addr_q.push_back(row_addr[i]);
                exp_data_q.push_back(row_data[i]);
            end
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < exp_addr_q.size(); i++)
            wait_for_store(i);
        repeat (40) @(posedge clk);  // catch late duplicate stores
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hdl/rv32i_pkg.sv
hdl/pipeline_status_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_writeback.sv
hdl/pipeline_control.sv
hdl/rv32i_pipeline.sv
sim/rv32i_pipeline_checker.sv
sim/rv32i_pipeline_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module rv32i_pipeline_tb -Mdir obj_dir
	./obj_dir/Vrv32i_pipeline_tb

clean:
	rm -rf obj_dir
